//--- source/cpu_debug_pkg.sv
package cpu_debug_pkg;

	////////////////////////////////////////
	// Sizes

	localparam int REG_WIDTH   = 16;
	localparam int REG_COUNT   = 8;
	localparam int ADDR_WIDTH  = $clog2(REG_COUNT);
	localparam int BYTE_WIDTH  = 8;
	localparam int DEBUG_WIDTH = REG_COUNT * REG_WIDTH;

	localparam int QUEUE_DEPTH = 8;
	localparam int PTR_WIDTH   = $clog2(QUEUE_DEPTH);
	localparam int COUNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

	typedef logic [REG_WIDTH-1:0]   reg_value_t;
	typedef logic [ADDR_WIDTH-1:0]  reg_addr_t;
	typedef logic [BYTE_WIDTH-1:0]  byte_t;
	typedef logic [PTR_WIDTH-1:0]   queue_ptr_t;
	typedef logic [COUNT_WIDTH-1:0] queue_count_t;

	////////////////////////////////////////
	// Host command bytes

	// Set in the first byte of a write, index in bits 2..0
	localparam int CMD_WRITE_BIT = 7;

	typedef enum logic [1:0] {
		CMD,
		HIGH,
		LOW
	} decoder_state_t;

	////////////////////////////////////////
	// LED pages, selected by sw[15:8]

	localparam byte_t PAGE_STATUS      = 8'h00;
	localparam byte_t PAGE_REG_ADDRS   = 8'h06;
	localparam byte_t PAGE_WRITE_VALUE = 8'h07;
	localparam byte_t PAGE_READ_VALUE1 = 8'h08;
	localparam byte_t PAGE_READ_VALUE2 = 8'h09;
	// Register i shows on PAGE_REG_BASE + i
	localparam byte_t PAGE_REG_BASE    = 8'h30;
	localparam byte_t PAGE_QUEUE_PTRS  = 8'h40;
	localparam byte_t PAGE_QUEUE_FRONT = 8'h41;

endpackage

//--- source/byte_queue.sv
`timescale 1ns/100ps

module byte_queue (
	input  logic                      clk,
	input  logic                      rst,

	input  logic                      push,
	input  cpu_debug_pkg::byte_t      push_byte,
	input  logic                      pop,

	output logic                      rx_credit,
	output logic                      queue_empty,
	output cpu_debug_pkg::byte_t      queue_front,

	output cpu_debug_pkg::queue_ptr_t qfront,
	output cpu_debug_pkg::queue_ptr_t qtail
);
	import cpu_debug_pkg::*;

	byte_t        entries [QUEUE_DEPTH];
	queue_count_t count;

	// Storage, written at the tail
	always_ff @(posedge clk) begin
		if (push) begin
			entries[qtail] <= push_byte;
		end
	end

	// Pointers wrap on their own width
	always_ff @(posedge clk) begin
		if (rst) begin
			qfront <= '0;
			qtail  <= '0;
		end else begin
			if (push) begin
				qtail <= qtail + 1'b1;
			end
			if (pop) begin
				qfront <= qfront + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// One credit back to the host per popped byte
	always_ff @(posedge clk) begin
		if (rst) begin
			rx_credit <= 1'b0;
		end else begin
			rx_credit <= pop;
		end
	end

	assign queue_empty = (count == '0);
	assign queue_front = entries[qfront];

endmodule

//--- source/reg_write_decoder.sv
`timescale 1ns/100ps

module reg_write_decoder (
	input  logic                      clk,
	input  logic                      rst,

	input  logic                      queue_empty,
	input  cpu_debug_pkg::byte_t      queue_front,
	output logic                      pop,

	output logic                      wr_en,
	output cpu_debug_pkg::reg_addr_t  wr_addr,
	output cpu_debug_pkg::reg_value_t wr_value,

	output cpu_debug_pkg::reg_addr_t  last_addr,
	output cpu_debug_pkg::reg_value_t last_value,
	output logic                      decoder_error
);
	import cpu_debug_pkg::*;

	decoder_state_t state;
	reg_addr_t      cmd_addr;
	byte_t          high_byte;

	// Take one byte every cycle the queue has one
	assign pop = !queue_empty;

	// Write goes out together with the low byte pop
	assign wr_en    = pop && (state == LOW);
	assign wr_addr  = cmd_addr;
	assign wr_value = {high_byte, queue_front};

	////////////////////////////////////////
	// Command FSM

	always_ff @(posedge clk) begin
		if (rst) begin
			state         <= CMD;
			decoder_error <= 1'b0;
		end else if (pop) begin
			case (state)
				CMD: begin
					if (queue_front[CMD_WRITE_BIT]) begin
						state <= HIGH;
					end else begin
						// Dropped byte, flag held until reset
						decoder_error <= 1'b1;
					end
				end
				HIGH:    state <= LOW;
				LOW:     state <= CMD;
				default: state <= CMD;
			endcase
		end
	end

	// Latched command fields
	always_ff @(posedge clk) begin
		if (pop && state == CMD) begin
			cmd_addr <= queue_front[ADDR_WIDTH-1:0];
		end
		if (pop && state == HIGH) begin
			high_byte <= queue_front;
		end
	end

	// Last completed write, for the LED pages
	always_ff @(posedge clk) begin
		if (rst) begin
			last_addr  <= '0;
			last_value <= '0;
		end else if (wr_en) begin
			last_addr  <= wr_addr;
			last_value <= wr_value;
		end
	end

endmodule

//--- source/register_file.sv
`timescale 1ns/100ps

module register_file (
	input  logic                      clk,
	input  logic                      rst,

	input  logic                      wr_en,
	input  cpu_debug_pkg::reg_addr_t  wr_addr,
	input  cpu_debug_pkg::reg_value_t wr_value,

	input  cpu_debug_pkg::reg_addr_t  read_addr1,
	input  cpu_debug_pkg::reg_addr_t  read_addr2,
	output cpu_debug_pkg::reg_value_t read_value1,
	output cpu_debug_pkg::reg_value_t read_value2,

	output logic [cpu_debug_pkg::DEBUG_WIDTH-1:0] reg_debug_out
);
	import cpu_debug_pkg::*;

	reg_value_t regs [REG_COUNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_value;
		end
	end

	// Asynchronous read ports
	assign read_value1 = regs[read_addr1];
	assign read_value2 = regs[read_addr2];

	////////////////////////////////////////
	// Flat view of all registers

	// Register 0 in the low bits
	for (genvar i = 0; i < REG_COUNT; i++) begin : g_debug
		assign reg_debug_out[i*REG_WIDTH +: REG_WIDTH] = regs[i];
	end

endmodule

//--- source/led_ctrl.sv
`timescale 1ns/100ps

module led_ctrl (
	input  cpu_debug_pkg::reg_value_t sw,

	input  cpu_debug_pkg::reg_addr_t  last_addr,
	input  cpu_debug_pkg::reg_value_t last_value,

	input  cpu_debug_pkg::reg_addr_t  read_addr1,
	input  cpu_debug_pkg::reg_addr_t  read_addr2,
	input  cpu_debug_pkg::reg_value_t read_value1,
	input  cpu_debug_pkg::reg_value_t read_value2,

	input  logic [cpu_debug_pkg::DEBUG_WIDTH-1:0] reg_debug_out,

	input  cpu_debug_pkg::queue_ptr_t qfront,
	input  cpu_debug_pkg::queue_ptr_t qtail,
	input  cpu_debug_pkg::byte_t      qfrontv,
	input  logic                      queue_empty,
	input  logic                      decoder_error,

	output cpu_debug_pkg::reg_value_t led_data
);
	import cpu_debug_pkg::*;

	byte_t     page;
	byte_t     reg_offset;
	reg_addr_t reg_index;
	logic      reg_page;

	assign page = sw[15:8];

	// Below the base the offset wraps high and misses the range
	assign reg_offset = page - PAGE_REG_BASE;
	assign reg_page   = (reg_offset < REG_COUNT);
	assign reg_index  = reg_offset[ADDR_WIDTH-1:0];

	////////////////////////////////////////
	// Page mux

	always_comb begin
		case (page)
			PAGE_STATUS: begin
				led_data = {queue_empty, 1'b0, decoder_error, 13'b0};
			end
			PAGE_REG_ADDRS: begin
				// One nibble per address
				led_data = {1'b0, last_addr, 1'b0, read_addr1, 1'b0, read_addr2, 4'b0};
			end
			PAGE_WRITE_VALUE: begin
				led_data = last_value;
			end
			PAGE_READ_VALUE1: begin
				led_data = read_value1;
			end
			PAGE_READ_VALUE2: begin
				led_data = read_value2;
			end
			PAGE_QUEUE_PTRS: begin
				led_data = {5'b0, qfront, 5'b0, qtail};
			end
			PAGE_QUEUE_FRONT: begin
				led_data = {8'b0, qfrontv};
			end
			default: begin
				// Register pages, else switches pass through
				if (reg_page) begin
					led_data = reg_debug_out[reg_index*REG_WIDTH +: REG_WIDTH];
				end else begin
					led_data = sw;
				end
			end
		endcase
	end

endmodule

//--- source/debug_board_top.sv
`timescale 1ns/100ps

module debug_board_top (
	input  logic                      clk,
	input  logic                      rst,

	input  cpu_debug_pkg::reg_value_t sw,

	input  logic                      rx_valid,
	input  cpu_debug_pkg::byte_t      rx_byte,
	output logic                      rx_credit,

	output cpu_debug_pkg::reg_value_t led_data
);
	import cpu_debug_pkg::*;

	logic       pop;
	logic       queue_empty;
	byte_t      queue_front;
	queue_ptr_t qfront;
	queue_ptr_t qtail;

	logic       wr_en;
	reg_addr_t  wr_addr;
	reg_value_t wr_value;
	reg_addr_t  last_addr;
	reg_value_t last_value;
	logic       decoder_error;

	reg_addr_t  read_addr1;
	reg_addr_t  read_addr2;
	reg_value_t read_value1;
	reg_value_t read_value2;

	logic [DEBUG_WIDTH-1:0] reg_debug_out;

	// Read addresses straight from the low switches
	assign read_addr1 = sw[2:0];
	assign read_addr2 = sw[6:4];

	////////////////////////////////////////
	// Blocks

	byte_queue u_byte_queue (
		.clk         (clk),
		.rst         (rst),
		.push        (rx_valid),
		.push_byte   (rx_byte),
		.pop         (pop),
		.rx_credit   (rx_credit),
		.queue_empty (queue_empty),
		.queue_front (queue_front),
		.qfront      (qfront),
		.qtail       (qtail)
	);

	reg_write_decoder u_reg_write_decoder (
		.clk           (clk),
		.rst           (rst),
		.queue_empty   (queue_empty),
		.queue_front   (queue_front),
		.pop           (pop),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_value      (wr_value),
		.last_addr     (last_addr),
		.last_value    (last_value),
		.decoder_error (decoder_error)
	);

	register_file u_register_file (
		.clk           (clk),
		.rst           (rst),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_value      (wr_value),
		.read_addr1    (read_addr1),
		.read_addr2    (read_addr2),
		.read_value1   (read_value1),
		.read_value2   (read_value2),
		.reg_debug_out (reg_debug_out)
	);

	led_ctrl u_led_ctrl (
		.sw            (sw),
		.last_addr     (last_addr),
		.last_value    (last_value),
		.read_addr1    (read_addr1),
		.read_addr2    (read_addr2),
		.read_value1   (read_value1),
		.read_value2   (read_value2),
		.reg_debug_out (reg_debug_out),
		.qfront        (qfront),
		.qtail         (qtail),
		.qfrontv       (queue_front),
		.queue_empty   (queue_empty),
		.decoder_error (decoder_error),
		.led_data      (led_data)
	);

endmodule

//--- verification/debug_board_tb.sv
`timescale 1ns/100ps

module debug_board_tb;
	import cpu_debug_pkg::*;

	localparam int WRITE_CMDS     = 40;
	localparam int READ_CHECKS    = 8;
	localparam int BURSTS         = 2;
	localparam int BURST_CMDS     = 8;
	localparam int SPACED_CMDS    = 8;
	// One malformed byte and the write that follows it
	localparam int PLANNED_BYTES  = 3 * (WRITE_CMDS + BURSTS * BURST_CMDS + SPACED_CMDS) + 4;
	localparam int TIMEOUT_CYCLES = 4 * (PLANNED_BYTES + 64);

	logic       clk;
	logic       rst;
	reg_value_t sw;
	logic       rx_valid;
	byte_t      rx_byte;
	logic       rx_credit;
	reg_value_t led_data;

	logic [15:0] lfsr;
	int          sent;
	int          credit_pulses;
	int          credits;
	int          cycles = 0;

	// Queue occupancy model with one pop per cycle while bytes wait
	int         push_count;
	int         pop_count;
	logic       credit_expected;
	reg_value_t ptr_word;
	byte_t      model_queue [QUEUE_DEPTH];
	reg_value_t front_word;

	reg_value_t model_regs [REG_COUNT];
	reg_addr_t  model_last_addr;
	reg_value_t model_last_value;
	logic       model_error;

	debug_board_top UUT (
		.clk       (clk),
		.rst       (rst),
		.sw        (sw),
		.rx_valid  (rx_valid),
		.rx_byte   (rx_byte),
		.rx_credit (rx_credit),
		.led_data  (led_data)
	);

	initial clk = 1'b0;

	always begin
		#10 clk = ~clk;
	end

	////////////////////////////////////////
	// Failure reporting

	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic report_mismatch(input string name, input reg_value_t expected,
			input reg_value_t actual);
		stop_on_failure($sformatf("FAIL time=%0t %s expected=%h actual=%h",
			$time, name, expected, actual));
	endtask

	////////////////////////////////////////
	// Random numbers

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// One LFSR step per bit
	task automatic take_bits(input int n, output reg_value_t value);
		value = '0;
		for (int k = 0; k < n; k++) begin
			lfsr  = lfsr_next(lfsr);
			value = {value[14:0], lfsr[0]};
		end
	endtask

	////////////////////////////////////////
	// Host sender

	task automatic send_byte(input byte_t b);
		while (credits == 0) begin
			@(posedge clk);
			rx_valid <= 1'b0;
		end
		@(posedge clk);
		rx_valid <= 1'b1;
		rx_byte  <= b;
		sent++;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			rx_valid <= 1'b0;
		end
	endtask

	task automatic send_write(input reg_addr_t idx, input reg_value_t value,
			input logic [3:0] filler, input logic spaced);
		byte_t      cmd_bytes [3];
		reg_value_t gap;
		// Bits 6..3 of the command byte carry junk
		cmd_bytes[0] = {1'b1, filler, idx};
		cmd_bytes[1] = value[15:8];
		cmd_bytes[2] = value[7:0];
		for (int k = 0; k < 3; k++) begin
			send_byte(cmd_bytes[k]);
			if (spaced) begin
				take_bits(2, gap);
				idle_cycles(int'(gap[1:0]));
			end
		end
		model_regs[idx]  = value;
		model_last_addr  = idx;
		model_last_value = value;
	endtask

	task automatic send_random_write(input logic spaced);
		reg_value_t a;
		reg_value_t v;
		reg_value_t f;
		take_bits(3, a);
		take_bits(16, v);
		take_bits(4, f);
		send_write(a[2:0], v, f[3:0], spaced);
	endtask

	// Ends one clock after the STATUS page shows the queue empty
	task automatic wait_drain();
		@(posedge clk);
		rx_valid <= 1'b0;
		sw       <= {PAGE_STATUS, 8'h00};
		@(negedge clk);
		while (!led_data[15]) begin
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	////////////////////////////////////////
	// Page checks

	task automatic check_page(input byte_t page, input byte_t low,
			input reg_value_t expected, input string name);
		@(posedge clk);
		sw <= {page, low};
		@(negedge clk);
		assert (led_data === expected) else report_mismatch(name, expected, led_data);
	endtask

	task automatic check_registers();
		for (int i = 0; i < REG_COUNT; i++) begin
			check_page(byte_t'(PAGE_REG_BASE + i), 8'h00, model_regs[i],
				$sformatf("led_data reg%0d", i));
		end
	endtask

	task automatic check_passthrough(input byte_t page);
		reg_value_t r;
		take_bits(8, r);
		check_page(page, r[7:0], {page, r[7:0]}, $sformatf("led_data page %h", page));
	endtask

	////////////////////////////////////////
	// Monitors and models

	assign credits    = QUEUE_DEPTH - sent + credit_pulses;
	assign ptr_word   = {5'b0, queue_ptr_t'(pop_count), 5'b0, queue_ptr_t'(push_count)};
	assign front_word = {8'h00, model_queue[queue_ptr_t'(pop_count)]};

	always @(negedge clk) begin
		if (rst) begin
			credit_pulses = 0;
		end else if (rx_credit) begin
			credit_pulses++;
		end
	end

	always @(posedge clk) begin
		if (rst) begin
			push_count      = 0;
			pop_count       = 0;
			credit_expected = 1'b0;
		end else begin
			credit_expected = (push_count != pop_count);
			if (credit_expected) begin
				pop_count++;
			end
			if (rx_valid) begin
				model_queue[queue_ptr_t'(push_count)] = rx_byte;
				push_count++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			stop_on_failure($sformatf("Timeout: test did not finish within %0d clock cycles",
				TIMEOUT_CYCLES));
		end
	end

	assert property (@(negedge clk) disable iff (rst)
		(credits >= 0) && (credits <= QUEUE_DEPTH))
		else stop_on_failure($sformatf("Sender credit count left its range: %0d", credits));

	assert property (@(negedge clk) disable iff (rst) rx_credit == credit_expected)
		else report_mismatch("rx_credit", reg_value_t'(credit_expected),
			reg_value_t'(rx_credit));

	assert property (@(negedge clk) disable iff (rst)
		(sw[15:8] == PAGE_QUEUE_PTRS) |-> (led_data == ptr_word))
		else report_mismatch("led_data queue pointers", ptr_word, led_data);

	assert property (@(negedge clk) disable iff (rst)
		(sw[15:8] == PAGE_QUEUE_FRONT) |-> (led_data == front_word))
		else report_mismatch("led_data queue front", front_word, led_data);

	assert property (@(negedge clk) disable iff (rst)
		(sw[15:8] == PAGE_STATUS) |-> (led_data[15] == (push_count == pop_count)))
		else report_mismatch("led_data[15]", reg_value_t'(push_count == pop_count),
			reg_value_t'(led_data[15]));

	////////////////////////////////////////
	// Test sequence

	initial begin
		reg_value_t r;
		reg_addr_t  ra1;
		reg_addr_t  ra2;

		lfsr     = 16'd53168;
		rst      = 1'b1;
		sw       = '0;
		rx_valid = 1'b0;
		rx_byte  = '0;
		sent     = 0;
		for (int i = 0; i < REG_COUNT; i++) begin
			model_regs[i] = '0;
		end
		model_last_addr  = '0;
		model_last_value = '0;
		model_error      = 1'b0;

		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// Reset state
		@(negedge clk);
		assert (rx_credit === 1'b0) else report_mismatch("rx_credit", 16'h0000,
			reg_value_t'(rx_credit));
		check_registers();
		check_page(PAGE_STATUS, 8'h00, 16'h8000, "led_data status");
		check_page(PAGE_QUEUE_PTRS, 8'h00, 16'h0000, "led_data queue pointers");

		// Random writes with idle gaps between commands
		for (int n = 0; n < WRITE_CMDS; n++) begin
			send_random_write(1'b0);
			take_bits(2, r);
			idle_cycles(int'(r[1:0]));
		end
		wait_drain();
		check_registers();
		check_page(PAGE_WRITE_VALUE, 8'h00, model_last_value, "led_data write value");
		take_bits(3, r);
		ra1 = r[2:0];
		take_bits(3, r);
		ra2 = r[2:0];
		check_page(PAGE_REG_ADDRS, {1'b0, ra2, 1'b0, ra1},
			{1'b0, model_last_addr, 1'b0, ra1, 1'b0, ra2, 4'h0}, "led_data register addresses");

		// Read ports through the low switches
		for (int n = 0; n < READ_CHECKS; n++) begin
			take_bits(3, r);
			ra1 = r[2:0];
			take_bits(3, r);
			ra2 = r[2:0];
			check_page(PAGE_READ_VALUE1, {1'b0, ra2, 1'b0, ra1}, model_regs[ra1],
				"led_data read value 1");
			check_page(PAGE_READ_VALUE2, {1'b0, ra2, 1'b0, ra1}, model_regs[ra2],
				"led_data read value 2");
		end

		// Back to back bursts with the front byte page watched
		for (int b = 0; b < BURSTS; b++) begin
			check_page(PAGE_QUEUE_FRONT, 8'h00, front_word, "led_data queue front");
			for (int c = 0; c < BURST_CMDS; c++) begin
				send_random_write(1'b0);
			end
			wait_drain();
			assert (credit_pulses == sent) else report_mismatch("rx_credit pulse count",
				reg_value_t'(sent), reg_value_t'(credit_pulses));
		end
		check_registers();

		// Command byte without the write bit
		take_bits(7, r);
		send_byte({1'b0, r[6:0]});
		model_error = 1'b1;
		wait_drain();
		check_page(PAGE_STATUS, 8'h00, {1'b1, 1'b0, model_error, 13'b0}, "led_data status");
		send_random_write(1'b0);
		wait_drain();
		check_registers();
		check_page(PAGE_STATUS, 8'h00, {1'b1, 1'b0, model_error, 13'b0}, "led_data status");

		// Pages outside the map show the switches
		check_passthrough(8'h05);
		check_passthrough(8'h50);
		check_passthrough(8'h2F);
		check_passthrough(8'h38);

		// Pointer page watched every cycle while bytes trickle in
		check_page(PAGE_QUEUE_PTRS, 8'h00, ptr_word, "led_data queue pointers");
		for (int n = 0; n < SPACED_CMDS; n++) begin
			send_random_write(1'b1);
		end
		wait_drain();
		check_page(PAGE_QUEUE_PTRS, 8'h00,
			{5'b0, queue_ptr_t'(sent), 5'b0, queue_ptr_t'(sent)}, "led_data queue pointers");
		check_registers();
		assert (credit_pulses == sent) else report_mismatch("rx_credit pulse count",
			reg_value_t'(sent), reg_value_t'(credit_pulses));

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- tb.f
source/cpu_debug_pkg.sv
source/byte_queue.sv
source/reg_write_decoder.sv
source/register_file.sv
source/led_ctrl.sv
source/debug_board_top.sv
verification/debug_board_tb.sv

//--- Makefile
# Verilator simulation of the debug board testbench

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        := debug_board_tb
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass or fail comes from the log, not from the simulator exit code
run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
